/* cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Address of the first instruction fetch
`define CPU_RESET_PC 32'h0020_0000

`define CPU_NUM_REGS 32
`define CPU_REG_W 5

// Instruction field widths
`define CPU_OPCODE_W 7
`define CPU_IMM_W 15

`define CPU_FLAGS_W 5

// Bytes per data word, also the PC step
`define CPU_WORD_BYTES 4

`endif

/* cpu_isa_pkg.sv */
`include "cpu_macros.svh"

package cpu_isa_pkg;

	typedef logic [`CPU_WORD_BYTES*8-1:0] word_t;
	typedef logic [`CPU_REG_W-1:0] reg_index_t;
	typedef logic [`CPU_IMM_W-1:0] imm_t;

	// equal, unsigned greater, unsigned less, signed greater, signed less
	typedef logic [`CPU_FLAGS_W-1:0] flags_t;

	typedef enum logic [`CPU_OPCODE_W-1:0] {
		OP_MOV = 7'h00, OP_LDL = 7'h01, OP_LDH = 7'h02,
		OP_ADD = 7'h10, OP_SUB = 7'h11, OP_OR = 7'h12, OP_AND = 7'h13,
		OP_ADDI = 7'h18, OP_ORI = 7'h1A, OP_ANDI = 7'h1B, OP_RSBI = 7'h1C,
		OP_STB = 7'h20, OP_STH = 7'h21, OP_STW = 7'h22,
		OP_LDBU = 7'h23, OP_LDBS = 7'h24, OP_LDHU = 7'h25, OP_LDHS = 7'h26,
		OP_LDW = 7'h27,
		OP_CMP = 7'h30, OP_CMPI = 7'h31, OP_BR = 7'h32
	} opcode_e;

	typedef struct packed {
		imm_t ob;
		reg_index_t oa;
		reg_index_t oc;
		opcode_e opcode;
	} instr_t;

	// Offsets and arithmetic immediates are sign-extended from ob
	function automatic word_t imm_sext(imm_t imm);
		return {{($bits(word_t) - `CPU_IMM_W){imm[`CPU_IMM_W-1]}}, imm};
	endfunction

endpackage

/* cpu_bus_pkg.sv */
`include "cpu_macros.svh"

package cpu_bus_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [7:0] byte_t;

	// One byte beat on the memory bus
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic read;
		logic write;
	} mem_req_t;

	typedef enum logic [1:0] {XFER_BYTE, XFER_HALF, XFER_WORD} xfer_size_e;

	typedef struct packed {
		addr_t addr;
		logic [`CPU_WORD_BYTES*8-1:0] wdata;
		xfer_size_e size;
		logic write;
		logic sign_ext;
	} xfer_req_t;

endpackage

/* reg_file.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file (
	input  logic clk,
	input  cpu_isa_pkg::reg_index_t rd_a,
	input  cpu_isa_pkg::reg_index_t rd_b,
	input  cpu_isa_pkg::reg_index_t rd_c,
	output cpu_isa_pkg::word_t rd_a_data,
	output cpu_isa_pkg::word_t rd_b_data,
	output cpu_isa_pkg::word_t rd_c_data,
	input  logic wr_en,
	input  cpu_isa_pkg::reg_index_t wr_index,
	input  cpu_isa_pkg::word_t wr_data,
	output cpu_isa_pkg::word_t debug
);

	cpu_isa_pkg::word_t regs [`CPU_NUM_REGS];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[wr_index] <= wr_data;
		end
	end

	assign rd_a_data = regs[rd_a];
	assign rd_b_data = regs[rd_b];
	assign rd_c_data = regs[rd_c];

	// Register 0 doubles as the debug output
	assign debug = regs[0];

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
	input  cpu_isa_pkg::instr_t instr,
	input  cpu_isa_pkg::word_t a,
	input  cpu_isa_pkg::word_t b,
	input  cpu_isa_pkg::word_t c,
	output cpu_isa_pkg::word_t result,
	output cpu_isa_pkg::flags_t flags
);

	cpu_isa_pkg::word_t imm_s;
	cpu_isa_pkg::word_t imm_z;
	cpu_isa_pkg::word_t cmp_rhs;

	assign imm_s = cpu_isa_pkg::imm_sext(instr.ob);
	assign imm_z = cpu_isa_pkg::word_t'(instr.ob);

	always_comb begin
		case (instr.opcode)
			cpu_isa_pkg::OP_MOV:  result = a;
			cpu_isa_pkg::OP_LDL:  result = {16'h0, instr.oa[0], instr.ob};
			// High half load leaves the low half of the target alone
			cpu_isa_pkg::OP_LDH:  result = {instr.oa[0], instr.ob, c[15:0]};
			cpu_isa_pkg::OP_ADD:  result = a + b;
			cpu_isa_pkg::OP_SUB:  result = a - b;
			cpu_isa_pkg::OP_OR:   result = a | b;
			cpu_isa_pkg::OP_AND:  result = a & b;
			cpu_isa_pkg::OP_ADDI: result = a + imm_s;
			cpu_isa_pkg::OP_ORI:  result = a | imm_z;
			cpu_isa_pkg::OP_ANDI: result = a & imm_z;
			cpu_isa_pkg::OP_RSBI: result = imm_s - a;
			default:              result = '0;
		endcase
	end

	assign cmp_rhs = (instr.opcode == cpu_isa_pkg::OP_CMPI) ? imm_s : b;

	assign flags = {
		a == cmp_rhs,
		a > cmp_rhs,
		a < cmp_rhs,
		$signed(a) > $signed(cmp_rhs),
		$signed(a) < $signed(cmp_rhs)
	};

endmodule

/* mem_sequencer.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mem_sequencer (
	input  logic clk,
	input  logic reset,
	input  cpu_bus_pkg::xfer_req_t xfer,
	input  logic xfer_start,
	output cpu_isa_pkg::word_t xfer_rdata,
	output logic xfer_done,
	output cpu_bus_pkg::mem_req_t mem_req,
	input  cpu_bus_pkg::byte_t mem_rdata,
	input  logic mem_ready
);

	typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_STROBE, SEQ_WAIT} seq_state_e;
	typedef logic [$clog2(`CPU_WORD_BYTES)-1:0] beat_t;

	seq_state_e state;
	cpu_bus_pkg::xfer_req_t req;
	cpu_bus_pkg::xfer_req_t issue_src;
	beat_t beat;
	beat_t last_beat;
	beat_t issue_beat;
	logic issue;
	cpu_bus_pkg::addr_t bus_addr;
	cpu_bus_pkg::byte_t bus_wdata;
	logic bus_read;
	logic bus_write;
	cpu_isa_pkg::word_t assembled;
	cpu_isa_pkg::word_t merged;
	cpu_isa_pkg::word_t extended;

	always_comb begin
		case (req.size)
			cpu_bus_pkg::XFER_BYTE: last_beat = beat_t'(0);
			cpu_bus_pkg::XFER_HALF: last_beat = beat_t'(1);
			default:                last_beat = beat_t'(`CPU_WORD_BYTES - 1);
		endcase
	end

	// Source of the next strobe. From idle the request is taken straight off the link
	always_comb begin
		issue_src = req;
		issue_beat = beat;
		if (state == SEQ_IDLE) begin
			issue_src = xfer;
			issue_beat = '0;
		end else if (state == SEQ_WAIT) begin
			issue_beat = beat + beat_t'(1);
		end
	end

	assign issue = mem_ready && ((state == SEQ_IDLE && xfer_start) || state == SEQ_ISSUE ||
		(state == SEQ_WAIT && beat != last_beat));

	always_comb begin
		merged = assembled;
		merged[beat*8 +: 8] = mem_rdata;
		case (req.size)
			cpu_bus_pkg::XFER_BYTE: extended = {{24{req.sign_ext & merged[7]}}, merged[7:0]};
			cpu_bus_pkg::XFER_HALF: extended = {{16{req.sign_ext & merged[15]}}, merged[15:0]};
			default:                extended = merged;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= SEQ_IDLE;
			beat <= '0;
			bus_read <= 1'b0;
			bus_write <= 1'b0;
			xfer_done <= 1'b0;
		end else begin
			// Strobes and done last one cycle unless a new beat is issued
			bus_read <= issue && !issue_src.write;
			bus_write <= issue && issue_src.write;
			xfer_done <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (xfer_start) begin
						beat <= '0;
						state <= mem_ready ? SEQ_STROBE : SEQ_ISSUE;
					end
				end
				SEQ_ISSUE: if (mem_ready) state <= SEQ_STROBE;
				SEQ_STROBE: state <= SEQ_WAIT;
				SEQ_WAIT: begin
					if (mem_ready && beat == last_beat) begin
						xfer_done <= 1'b1;
						state <= SEQ_IDLE;
					end else if (mem_ready) begin
						beat <= beat + beat_t'(1);
						state <= SEQ_STROBE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == SEQ_IDLE && xfer_start) begin
			req <= xfer;
		end
		if (issue) begin
			bus_addr <= issue_src.addr + cpu_bus_pkg::addr_t'(issue_beat);
			bus_wdata <= issue_src.wdata[issue_beat*8 +: 8];
		end
		// Read byte lands in the first ready cycle after its strobe
		if (state == SEQ_WAIT && mem_ready && !req.write) begin
			assembled <= merged;
			if (beat == last_beat) begin
				xfer_rdata <= extended;
			end
		end
	end

	assign mem_req = '{addr: bus_addr, wdata: bus_wdata, read: bus_read, write: bus_write};

	a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
		!(mem_req.read && mem_req.write));

	a_strobe_ready: assert property (@(posedge clk) disable iff (reset)
		(mem_req.read || mem_req.write) |-> $past(mem_ready));

endmodule

/* cpu_control.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_control (
	input  logic clk,
	input  logic reset,
	output cpu_bus_pkg::xfer_req_t xfer,
	output logic xfer_start,
	input  cpu_isa_pkg::word_t xfer_rdata,
	input  logic xfer_done,
	output cpu_isa_pkg::reg_index_t rd_a,
	output cpu_isa_pkg::reg_index_t rd_b,
	output cpu_isa_pkg::reg_index_t rd_c,
	input  cpu_isa_pkg::word_t rd_c_data,
	input  cpu_isa_pkg::word_t rd_a_data,
	output cpu_isa_pkg::instr_t instr,
	input  cpu_isa_pkg::word_t alu_result,
	input  cpu_isa_pkg::flags_t alu_flags,
	output logic wr_en,
	output cpu_isa_pkg::reg_index_t wr_index,
	output cpu_isa_pkg::word_t wr_data
);

	typedef enum logic [1:0] {FETCH, FETCH_WAIT, EXEC, MEM_WAIT} state_e;

	state_e state;
	cpu_bus_pkg::addr_t pc;
	cpu_isa_pkg::flags_t flags;
	cpu_isa_pkg::word_t offset;
	logic in_flight;
	logic is_alu_wr;
	logic is_load;
	logic is_store;
	cpu_bus_pkg::xfer_size_e mem_size;
	logic mem_sign;

	assign offset = cpu_isa_pkg::imm_sext(instr.ob);

	// Register ALU operations take their second operand index from ob[4:0]
	assign rd_a = instr.oa;
	assign rd_b = instr.ob[`CPU_REG_W-1:0];
	assign rd_c = instr.oc;

	always_comb begin
		is_alu_wr = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		mem_size = cpu_bus_pkg::XFER_WORD;
		mem_sign = 1'b0;
		case (instr.opcode)
			cpu_isa_pkg::OP_MOV, cpu_isa_pkg::OP_LDL, cpu_isa_pkg::OP_LDH,
			cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SUB, cpu_isa_pkg::OP_OR, cpu_isa_pkg::OP_AND,
			cpu_isa_pkg::OP_ADDI, cpu_isa_pkg::OP_ORI, cpu_isa_pkg::OP_ANDI,
			cpu_isa_pkg::OP_RSBI: is_alu_wr = 1'b1;
			cpu_isa_pkg::OP_STB: {is_store, mem_size} = {1'b1, cpu_bus_pkg::XFER_BYTE};
			cpu_isa_pkg::OP_STH: {is_store, mem_size} = {1'b1, cpu_bus_pkg::XFER_HALF};
			cpu_isa_pkg::OP_STW: is_store = 1'b1;
			cpu_isa_pkg::OP_LDBU: {is_load, mem_size} = {1'b1, cpu_bus_pkg::XFER_BYTE};
			cpu_isa_pkg::OP_LDBS: {is_load, mem_sign, mem_size} = {2'b11, cpu_bus_pkg::XFER_BYTE};
			cpu_isa_pkg::OP_LDHU: {is_load, mem_size} = {1'b1, cpu_bus_pkg::XFER_HALF};
			cpu_isa_pkg::OP_LDHS: {is_load, mem_sign, mem_size} = {2'b11, cpu_bus_pkg::XFER_HALF};
			cpu_isa_pkg::OP_LDW: is_load = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		if (state == FETCH) begin
			xfer = '{addr: pc, wdata: '0, size: cpu_bus_pkg::XFER_WORD, write: 1'b0, sign_ext: 1'b0};
		end else begin
			xfer = '{addr: rd_c_data + offset, wdata: rd_a_data, size: mem_size,
				write: is_store, sign_ext: mem_sign};
		end
	end

	assign xfer_start = (state == FETCH) || (state == EXEC && (is_load || is_store));

	assign wr_en = (state == EXEC && is_alu_wr) || (state == MEM_WAIT && xfer_done && is_load);
	assign wr_index = is_load ? instr.oa : instr.oc;
	assign wr_data = is_load ? xfer_rdata : alu_result;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= FETCH;
			pc <= `CPU_RESET_PC;
			flags <= '0;
			in_flight <= 1'b0;
		end else begin
			if (xfer_start) in_flight <= 1'b1;
			else if (xfer_done) in_flight <= 1'b0;
			case (state)
				FETCH: state <= FETCH_WAIT;
				FETCH_WAIT: begin
					if (xfer_done) begin
						pc <= pc + cpu_bus_pkg::addr_t'(`CPU_WORD_BYTES);
						state <= EXEC;
					end
				end
				EXEC: begin
					state <= (is_load || is_store) ? MEM_WAIT : FETCH;
					if (instr.opcode == cpu_isa_pkg::OP_CMP || instr.opcode == cpu_isa_pkg::OP_CMPI)
						flags <= alu_flags;
					// PC already points past the branch here
					if (instr.opcode == cpu_isa_pkg::OP_BR && (flags & instr.oa) != '0)
						pc <= pc + offset;
				end
				MEM_WAIT: if (xfer_done) state <= FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH_WAIT && xfer_done) begin
			instr <= cpu_isa_pkg::instr_t'(xfer_rdata);
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (reset) xfer_start |-> !in_flight);

	a_state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {FETCH, FETCH_WAIT, EXEC, MEM_WAIT});

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
	input  logic clk,
	input  logic reset,
	output cpu_bus_pkg::mem_req_t mem_req,
	input  cpu_bus_pkg::byte_t mem_rdata,
	input  logic mem_ready,
	output cpu_isa_pkg::word_t debug
);

	cpu_bus_pkg::xfer_req_t xfer;
	logic xfer_start;
	logic xfer_done;
	cpu_isa_pkg::word_t xfer_rdata;
	cpu_isa_pkg::reg_index_t rd_a;
	cpu_isa_pkg::reg_index_t rd_b;
	cpu_isa_pkg::reg_index_t rd_c;
	cpu_isa_pkg::word_t rd_a_data;
	cpu_isa_pkg::word_t rd_b_data;
	cpu_isa_pkg::word_t rd_c_data;
	cpu_isa_pkg::instr_t instr;
	cpu_isa_pkg::word_t alu_result;
	cpu_isa_pkg::flags_t alu_flags;
	logic wr_en;
	cpu_isa_pkg::reg_index_t wr_index;
	cpu_isa_pkg::word_t wr_data;

	cpu_control u_control (.clk, .reset, .xfer, .xfer_start, .xfer_rdata, .xfer_done,
		.rd_a, .rd_b, .rd_c, .rd_c_data, .rd_a_data, .instr, .alu_result, .alu_flags,
		.wr_en, .wr_index, .wr_data);

	reg_file u_reg_file (.clk, .rd_a, .rd_b, .rd_c, .rd_a_data, .rd_b_data, .rd_c_data,
		.wr_en, .wr_index, .wr_data, .debug);

	alu u_alu (.instr, .a(rd_a_data), .b(rd_b_data), .c(rd_c_data),
		.result(alu_result), .flags(alu_flags));

	mem_sequencer u_mem_sequencer (.clk, .reset, .xfer, .xfer_start, .xfer_rdata, .xfer_done,
		.mem_req, .mem_rdata, .mem_ready);

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset,
	input  logic reset_req
);

	task automatic hold_reset();
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset at start, and again whenever the testbench asks for a rerun
	initial begin
		hold_reset();
		forever begin
			@(posedge reset_req);
			hold_reset();
		end
	end

endmodule

/* tb_cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu_top;

	typedef enum logic [1:0] {ROW_REG, ROW_STORE, ROW_BRANCH} row_kind_e;

	typedef struct packed {
		logic [5:0] slot;
		cpu_isa_pkg::word_t instr;
		row_kind_e kind;
		cpu_isa_pkg::word_t exp_val;
		cpu_bus_pkg::addr_t exp_addr;
		logic [2:0] nbytes;
	} row_t;

	logic clk;
	logic reset;
	logic reset_req;
	cpu_bus_pkg::mem_req_t mem_req;
	cpu_bus_pkg::byte_t mem_rdata;
	logic mem_ready;
	cpu_isa_pkg::word_t debug;

	cpu_bus_pkg::byte_t mem [cpu_bus_pkg::addr_t];
	cpu_bus_pkg::addr_t fetch_q [$];
	cpu_bus_pkg::addr_t read_q [$];
	cpu_bus_pkg::mem_req_t write_q [$];
	row_t rows [$];
	logic random_ready;
	integer seed;
	int cycles;
	int limit;

	tb_clock u_clock (.clk, .reset, .reset_req);

	cpu_top UUT (.clk, .reset, .mem_req, .mem_rdata, .mem_ready, .debug);

	task automatic fail_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_word(cpu_isa_pkg::word_t got, cpu_isa_pkg::word_t exp, string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_addr(cpu_bus_pkg::addr_t got, cpu_bus_pkg::addr_t exp, string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_byte(cpu_bus_pkg::byte_t got, cpu_bus_pkg::byte_t exp, string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	// Instruction word holds ob, oa, oc and opcode from high to low
	function automatic cpu_isa_pkg::word_t enc(cpu_isa_pkg::opcode_e op, logic [4:0] oc,
		logic [4:0] oa, logic [14:0] ob);
		return {ob, oa, oc, op};
	endfunction

	// 16-bit immediate split over oa[0] and ob
	function automatic cpu_isa_pkg::word_t enc16(cpu_isa_pkg::opcode_e op, logic [4:0] oc,
		logic [15:0] v);
		return enc(op, oc, {4'b0, v[15]}, v[14:0]);
	endfunction

	function automatic cpu_bus_pkg::addr_t fetch_addr(int slot);
		return `CPU_RESET_PC + cpu_bus_pkg::addr_t'(slot * `CPU_WORD_BYTES);
	endfunction

	function automatic logic is_fetch(cpu_bus_pkg::addr_t a);
		return a >= `CPU_RESET_PC && a < `CPU_RESET_PC + 32'h100 && a[1:0] == 2'b00;
	endfunction

	function automatic cpu_bus_pkg::byte_t read_byte(cpu_bus_pkg::addr_t a);
		if (mem.exists(a))
			return mem[a];
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
	endfunction

	task automatic add_row(int slot, cpu_isa_pkg::word_t instr, row_kind_e kind,
		cpu_isa_pkg::word_t val, cpu_bus_pkg::addr_t addr, int n);
		row_t r;
		r.slot = 6'(slot);
		r.instr = instr;
		r.kind = kind;
		r.exp_val = val;
		r.exp_addr = addr;
		r.nbytes = 3'(n);
		rows.push_back(r);
	endtask

	task automatic build_table();
		cpu_isa_pkg::word_t v;
		cpu_isa_pkg::word_t r1;
		cpu_isa_pkg::word_t st;
		v = 32'h0000_8765;
		add_row(0, enc16(cpu_isa_pkg::OP_LDL, 5'd0, 16'h8765), ROW_REG, v, '0, 0);
		v = {16'h1234, v[15:0]};
		add_row(1, enc16(cpu_isa_pkg::OP_LDH, 5'd0, 16'h1234), ROW_REG, v, '0, 0);
		r1 = 32'hFFFF_00F0;
		add_row(2, enc16(cpu_isa_pkg::OP_LDL, 5'd1, 16'h00F0), ROW_REG, v, '0, 0);
		add_row(3, enc16(cpu_isa_pkg::OP_LDH, 5'd1, 16'hFFFF), ROW_REG, v, '0, 0);
		v = v + r1;
		add_row(4, enc(cpu_isa_pkg::OP_ADD, 5'd0, 5'd0, 15'd1), ROW_REG, v, '0, 0);
		v = v - r1;
		add_row(5, enc(cpu_isa_pkg::OP_SUB, 5'd0, 5'd0, 15'd1), ROW_REG, v, '0, 0);
		v = v | r1;
		add_row(6, enc(cpu_isa_pkg::OP_OR, 5'd0, 5'd0, 15'd1), ROW_REG, v, '0, 0);
		v = v & r1;
		add_row(7, enc(cpu_isa_pkg::OP_AND, 5'd0, 5'd0, 15'd1), ROW_REG, v, '0, 0);
		v = v + 32'hFFFF_FFF0;
		add_row(8, enc(cpu_isa_pkg::OP_ADDI, 5'd0, 5'd0, 15'h7FF0), ROW_REG, v, '0, 0);
		v = v | 32'h0000_4003;
		add_row(9, enc(cpu_isa_pkg::OP_ORI, 5'd0, 5'd0, 15'h4003), ROW_REG, v, '0, 0);
		v = v & 32'h0000_7F0F;
		add_row(10, enc(cpu_isa_pkg::OP_ANDI, 5'd0, 5'd0, 15'h7F0F), ROW_REG, v, '0, 0);
		v = 32'h0000_0100 - v;
		add_row(11, enc(cpu_isa_pkg::OP_RSBI, 5'd0, 5'd0, 15'h0100), ROW_REG, v, '0, 0);
		st = v;
		// Stores of r0 relative to r2
		add_row(12, enc16(cpu_isa_pkg::OP_LDL, 5'd2, 16'h1000), ROW_REG, v, '0, 0);
		add_row(13, enc(cpu_isa_pkg::OP_STB, 5'd2, 5'd0, 15'h0010), ROW_STORE, st, 32'h1010, 1);
		add_row(14, enc(cpu_isa_pkg::OP_STH, 5'd2, 5'd0, 15'h7FFE), ROW_STORE, st, 32'h0FFE, 2);
		add_row(15, enc(cpu_isa_pkg::OP_STW, 5'd2, 5'd0, 15'h0020), ROW_STORE, st, 32'h1020, 4);
		// Loads from the preset bytes 9A B7 3C 5E at 0x1100
		add_row(16, enc(cpu_isa_pkg::OP_LDBU, 5'd2, 5'd0, 15'h0100), ROW_REG, 32'h0000_009A, '0, 0);
		add_row(17, enc(cpu_isa_pkg::OP_LDBS, 5'd2, 5'd0, 15'h0100), ROW_REG, 32'hFFFF_FF9A, '0, 0);
		add_row(18, enc(cpu_isa_pkg::OP_LDHU, 5'd2, 5'd0, 15'h0100), ROW_REG, 32'h0000_B79A, '0, 0);
		add_row(19, enc(cpu_isa_pkg::OP_LDHS, 5'd2, 5'd0, 15'h0100), ROW_REG, 32'hFFFF_B79A, '0, 0);
		add_row(20, enc(cpu_isa_pkg::OP_LDW, 5'd2, 5'd0, 15'h0100), ROW_REG, 32'h5E3C_B79A, '0, 0);
		add_row(21, enc(cpu_isa_pkg::OP_LDBS, 5'd2, 5'd0, 15'h0103), ROW_REG, 32'h0000_005E, '0, 0);
		v = st;
		add_row(22, enc(cpu_isa_pkg::OP_LDW, 5'd2, 5'd0, 15'h0020), ROW_REG, v, '0, 0);
		// Negative r0 against 5 sets unsigned greater and signed less
		add_row(23, enc(cpu_isa_pkg::OP_CMPI, 5'd0, 5'd0, 15'h0005), ROW_REG, v, '0, 0);
		add_row(24, enc(cpu_isa_pkg::OP_BR, 5'd0, 5'b00001, 15'h0008), ROW_BRANCH, '0,
			fetch_addr(25) + 32'h8, 0);
		add_row(27, enc(cpu_isa_pkg::OP_BR, 5'd0, 5'b10000, 15'h0008), ROW_BRANCH, '0,
			fetch_addr(28), 0);
		// r0 above r1 as signed with both negative
		add_row(28, enc(cpu_isa_pkg::OP_CMP, 5'd0, 5'd0, 15'd1), ROW_REG, v, '0, 0);
		add_row(29, enc(cpu_isa_pkg::OP_BR, 5'd0, 5'b00010, 15'h0004), ROW_BRANCH, '0,
			fetch_addr(30) + 32'h4, 0);
		v = v + 32'h3;
		add_row(31, enc(cpu_isa_pkg::OP_ADDI, 5'd0, 5'd0, 15'h0003), ROW_REG, v, '0, 0);
		// Branch to itself so the program parks here
		add_row(32, enc(cpu_isa_pkg::OP_BR, 5'd0, 5'b11111, 15'h7FFC), ROW_BRANCH, '0,
			fetch_addr(33) - 32'h4, 0);
	endtask

	task automatic load_memory();
		cpu_bus_pkg::addr_t a;
		mem.delete();
		foreach (rows[i]) begin
			a = fetch_addr(int'(rows[i].slot));
			for (int b = 0; b < `CPU_WORD_BYTES; b++)
				mem[a + cpu_bus_pkg::addr_t'(b)] = rows[i].instr[b*8 +: 8];
		end
		mem[32'h1100] = 8'h9A;
		mem[32'h1101] = 8'hB7;
		mem[32'h1102] = 8'h3C;
		mem[32'h1103] = 8'h5E;
	endtask

	task automatic next_fetch(output cpu_bus_pkg::addr_t a);
		while (fetch_q.size() == 0)
			@(negedge clk);
		a = fetch_q.pop_front();
	endtask

	task automatic run_pass();
		cpu_bus_pkg::addr_t a;
		cpu_bus_pkg::addr_t exp_next;
		while (read_q.size() < `CPU_WORD_BYTES)
			@(negedge clk);
		for (int i = 0; i < `CPU_WORD_BYTES; i++)
			check_addr(read_q[i], `CPU_RESET_PC + cpu_bus_pkg::addr_t'(i), "reset fetch address");
		// Fetch of the first instruction
		next_fetch(a);
		foreach (rows[i]) begin
			// The next fetch strobe marks the end of this instruction
			next_fetch(a);
			if (rows[i].kind == ROW_BRANCH)
				exp_next = rows[i].exp_addr;
			else
				exp_next = fetch_addr(int'(rows[i].slot) + 1);
			check_addr(a, exp_next, "next fetch address");
			if (rows[i].kind == ROW_STORE) begin
				if (write_q.size() != int'(rows[i].nbytes)) begin
					$display("Store in slot %0d gave %0d write strobes instead of %0d",
						rows[i].slot, write_q.size(), rows[i].nbytes);
					fail_run();
				end
				foreach (write_q[j]) begin
					check_addr(write_q[j].addr, rows[i].exp_addr + cpu_bus_pkg::addr_t'(j),
						"store address");
					check_byte(write_q[j].wdata, rows[i].exp_val[j*8 +: 8], "store byte");
				end
			end else if (write_q.size() != 0) begin
				$display("Instruction in slot %0d wrote to memory", rows[i].slot);
				fail_run();
			end
			if (rows[i].kind == ROW_REG)
				check_word(debug, rows[i].exp_val, "debug");
			write_q.delete();
		end
	endtask

	// Memory model answers strobes on the falling edge
	always @(negedge clk) begin
		int r;
		r = $random(seed);
		mem_ready <= random_ready ? r[0] : 1'b1;
		if (mem_req.read) begin
			mem_rdata <= read_byte(mem_req.addr);
			read_q.push_back(mem_req.addr);
			if (is_fetch(mem_req.addr))
				fetch_q.push_back(mem_req.addr);
		end
		if (mem_req.write) begin
			mem[mem_req.addr] = mem_req.wdata;
			write_q.push_back(mem_req);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout after %0d cycles without finishing the program table", limit);
			fail_run();
		end
	end

	initial begin
		seed = 32'h9c19;
		reset_req = 1'b0;
		mem_ready = 1'b1;
		mem_rdata = '0;
		random_ready = 1'b0;
		cycles = 0;
		build_table();
		limit = rows.size() * 40 * 4;
		load_memory();
		run_pass();
		// Second pass from a fresh reset with random back-pressure
		reset_req = 1'b1;
		wait (reset);
		random_ready = 1'b1;
		fetch_q.delete();
		read_q.delete();
		write_q.delete();
		load_memory();
		@(negedge reset);
		reset_req = 1'b0;
		run_pass();
		$display("No errors");
		$finish;
	end

endmodule

/* cpu_top.f */
+incdir+.
cpu_isa_pkg.sv
cpu_bus_pkg.sv
reg_file.sv
alu.sv
mem_sequencer.sv
cpu_control.sv
cpu_top.sv
tb_clock.sv
tb_cpu_top.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_cpu_top
FILELIST := cpu_top.f
OBJ_DIR  := obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
